/* design/axi_sram_port.sv */
`timescale 1ns/1ns

module axi_sram_port import mem_bus_pkg::*; #(
  parameter bit CHECK_ALIGN = 1'b1
) (
  input  logic      aclk,
  input  logic      hard_resetn,
  input  logic      i_aw_valid,
  input  aw_t       i_aw,
  input  logic      i_w_valid,
  input  w_t        i_w,
  input  logic      i_b_ready,
  input  logic      i_ar_valid,
  input  ar_t       i_ar,
  input  logic      i_r_ready,
  input  logic      i_gnt,
  input  data_t     i_rdata,
  output logic      o_aw_ready,
  output logic      o_w_ready,
  output logic      o_b_valid,
  output resp_t     o_b_resp,
  output logic      o_ar_ready,
  output logic      o_r_valid,
  output r_t        o_r,
  output logic      o_req_valid,
  output sram_req_t o_req,
  output logic      o_active
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_GNT,
    ST_WAIT_RDATA,
    ST_RESP
  } state_t;

  state_t    state_q;
  sram_req_t req_q;
  logic      is_write_q;
  resp_t     resp_q;
  data_t     rdata_q;

  logic wr_acc;
  logic rd_acc;
  logic wr_misalign;
  logic rd_misalign;
  logic resp_done;

  assign wr_misalign = CHECK_ALIGN && (i_aw.addr[1:0] != 2'b00);
  assign rd_misalign = CHECK_ALIGN && (i_ar.addr[1:0] != 2'b00);

  // Write has priority over a read offered on the same cycle
  assign wr_acc = (state_q == ST_IDLE) && i_aw_valid && i_w_valid;
  assign rd_acc = (state_q == ST_IDLE) && i_ar_valid && !i_aw_valid && !i_w_valid;

  assign o_aw_ready  = wr_acc;
  assign o_w_ready   = wr_acc;
  assign o_ar_ready  = rd_acc;
  assign o_b_valid   = (state_q == ST_RESP) && is_write_q;
  assign o_r_valid   = (state_q == ST_RESP) && !is_write_q;
  assign o_b_resp    = resp_q;
  assign o_r         = '{data: rdata_q, resp: resp_q};
  assign o_req_valid = (state_q == ST_WAIT_GNT);
  assign o_req       = req_q;

  assign resp_done = (o_b_valid && i_b_ready) || (o_r_valid && i_r_ready);
  assign o_active  = wr_acc || rd_acc || resp_done;  // aw and w move together

  always_ff @(posedge aclk or negedge hard_resetn) begin
    if (!hard_resetn) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_acc) state_q <= wr_misalign ? ST_RESP : ST_WAIT_GNT;
          else if (rd_acc) state_q <= rd_misalign ? ST_RESP : ST_WAIT_GNT;
        end
        ST_WAIT_GNT: begin
          if (i_gnt) state_q <= is_write_q ? ST_RESP : ST_WAIT_RDATA;
        end
        ST_WAIT_RDATA: state_q <= ST_RESP;  // Array output valid now
        ST_RESP: begin
          if (resp_done) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_acc) begin
      req_q      <= '{we: 1'b1, waddr: i_aw.addr[ADDR_W-1:2], wdata: i_w.data, strb: i_w.strb};
      is_write_q <= 1'b1;
      resp_q     <= wr_misalign ? RESP_SLVERR : RESP_OKAY;
    end else if (rd_acc) begin
      req_q      <= '{we: 1'b0, waddr: i_ar.addr[ADDR_W-1:2], wdata: '0, strb: '0};
      is_write_q <= 1'b0;
      resp_q     <= rd_misalign ? RESP_SLVERR : RESP_OKAY;
      rdata_q    <= '0;  // Error reads return zero
    end else if (state_q == ST_WAIT_RDATA) begin
      rdata_q    <= i_rdata;
    end
  end

  // Response must wait for the master
  a_b_hold: assert property (@(posedge aclk) disable iff (!hard_resetn)
    o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b_resp));

  // Request held until the arbiter picks it
  a_req_hold: assert property (@(posedge aclk) disable iff (!hard_resetn)
    o_req_valid && !i_gnt |=> o_req_valid && $stable(o_req));

endmodule

/* design/bus_idle_watchdog.sv */
`timescale 1ns/1ns

module bus_idle_watchdog #(
  parameter int N_PORTS    = 3,
  parameter int IDLE_LIMIT = 1000
) (
  input  logic               aclk,
  input  logic               hard_resetn,
  input  logic [N_PORTS-1:0] i_active,
  output logic               o_timeout
);

  localparam int CNT_W = $clog2(IDLE_LIMIT + 1);

  logic [CNT_W-1:0] idle_cnt_q;
  logic             timeout_q;
  logic             any_active;

  assign any_active = |i_active;
  assign o_timeout  = timeout_q;

  always_ff @(posedge aclk or negedge hard_resetn) begin
    if (!hard_resetn) begin
      idle_cnt_q <= '0;
      timeout_q  <= 1'b0;
    end else begin
      if (any_active) begin
        idle_cnt_q <= '0;
      end else if (idle_cnt_q != CNT_W'(IDLE_LIMIT)) begin
        idle_cnt_q <= idle_cnt_q + 1'b1;  // Saturates at the limit
      end
      if (!any_active && idle_cnt_q == CNT_W'(IDLE_LIMIT - 1)) timeout_q <= 1'b1;
    end
  end

  // Sticky until reset
  a_timeout_sticky: assert property (@(posedge aclk) disable iff (!hard_resetn)
    o_timeout |=> o_timeout);

endmodule

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

  // ==================================================
  // Bus geometry
  // ==================================================
  localparam int ADDR_W  = 16;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int WORD_AW = ADDR_W - 2;  // Word address into the array

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Response codes
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // ==================================================
  // AXI channel payloads
  // ==================================================
  typedef struct packed {
    addr_t addr;
  } aw_t;

  typedef struct packed {
    addr_t addr;
  } ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_t;

  // Port to arbiter request
  typedef struct packed {
    logic               we;
    logic [WORD_AW-1:0] waddr;
    data_t              wdata;
    strb_t              strb;
  } sram_req_t;

endpackage

/* design/shared_sram_top.sv */
`timescale 1ns/1ns

module shared_sram_top import mem_bus_pkg::*; #(
  parameter int               N_PORTS          = 3,
  parameter int               IDLE_LIMIT       = 1000,
  parameter logic [N_PORTS-1:0] CHECK_ALIGN_MASK = '1
) (
  input  logic               aclk,
  input  logic               hard_resetn,
  input  logic [N_PORTS-1:0] i_aw_valid,
  input  aw_t                i_aw [N_PORTS],
  input  logic [N_PORTS-1:0] i_w_valid,
  input  w_t                 i_w [N_PORTS],
  input  logic [N_PORTS-1:0] i_b_ready,
  input  logic [N_PORTS-1:0] i_ar_valid,
  input  ar_t                i_ar [N_PORTS],
  input  logic [N_PORTS-1:0] i_r_ready,
  output logic [N_PORTS-1:0] o_aw_ready,
  output logic [N_PORTS-1:0] o_w_ready,
  output logic [N_PORTS-1:0] o_b_valid,
  output resp_t              o_b_resp [N_PORTS],
  output logic [N_PORTS-1:0] o_ar_ready,
  output logic [N_PORTS-1:0] o_r_valid,
  output r_t                 o_r [N_PORTS],
  output logic               o_timeout
);

  logic [N_PORTS-1:0] req_valid;
  sram_req_t          req [N_PORTS];
  logic [N_PORTS-1:0] gnt;
  logic [N_PORTS-1:0] active;
  logic               sram_en;
  sram_req_t          sram_req;
  data_t              sram_rdata;  // Shared by all ports

  // ==================================================
  // Slave ports
  // ==================================================
  for (genvar g = 0; g < N_PORTS; g++) begin : g_port
    axi_sram_port #(
      .CHECK_ALIGN (CHECK_ALIGN_MASK[g])
    ) axi_sram_port_i (
      .aclk        (aclk),
      .hard_resetn (hard_resetn),
      .i_aw_valid  (i_aw_valid[g]),
      .i_aw        (i_aw[g]),
      .i_w_valid   (i_w_valid[g]),
      .i_w         (i_w[g]),
      .i_b_ready   (i_b_ready[g]),
      .i_ar_valid  (i_ar_valid[g]),
      .i_ar        (i_ar[g]),
      .i_r_ready   (i_r_ready[g]),
      .i_gnt       (gnt[g]),
      .i_rdata     (sram_rdata),
      .o_aw_ready  (o_aw_ready[g]),
      .o_w_ready   (o_w_ready[g]),
      .o_b_valid   (o_b_valid[g]),
      .o_b_resp    (o_b_resp[g]),
      .o_ar_ready  (o_ar_ready[g]),
      .o_r_valid   (o_r_valid[g]),
      .o_r         (o_r[g]),
      .o_req_valid (req_valid[g]),
      .o_req       (req[g]),
      .o_active    (active[g])
    );
  end

  sram_arbiter #(.N_PORTS(N_PORTS)) sram_arbiter_i (
    .aclk        (aclk),
    .hard_resetn (hard_resetn),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_gnt       (gnt),
    .o_sram_en   (sram_en),
    .o_sram_req  (sram_req)
  );

  sram_array sram_array_i (
    .aclk    (aclk),
    .i_en    (sram_en),
    .i_req   (sram_req),
    .o_rdata (sram_rdata)
  );

  bus_idle_watchdog #(
    .N_PORTS    (N_PORTS),
    .IDLE_LIMIT (IDLE_LIMIT)
  ) bus_idle_watchdog_i (
    .aclk        (aclk),
    .hard_resetn (hard_resetn),
    .i_active    (active),
    .o_timeout   (o_timeout)
  );

endmodule

/* design/sram_arbiter.sv */
`timescale 1ns/1ns

module sram_arbiter import mem_bus_pkg::*; #(
  parameter int N_PORTS = 3
) (
  input  logic               aclk,
  input  logic               hard_resetn,
  input  logic [N_PORTS-1:0] i_req_valid,
  input  sram_req_t          i_req [N_PORTS],
  output logic [N_PORTS-1:0] o_gnt,
  output logic               o_sram_en,
  output sram_req_t          o_sram_req
);

  localparam int PTR_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  logic [PTR_W-1:0]   last_q;
  logic [PTR_W-1:0]   win;
  logic [N_PORTS-1:0] gnt;
  logic               found;

  // ==================================================
  // Round-robin pick starting after the last winner
  // ==================================================
  always_comb begin
    int idx;
    gnt   = '0;
    found = 1'b0;
    win   = last_q;
    for (int i = 1; i <= N_PORTS; i++) begin
      idx = (int'(last_q) + i) % N_PORTS;
      if (!found && i_req_valid[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        win      = PTR_W'(idx);
      end
    end
  end

  assign o_gnt      = gnt;
  assign o_sram_en  = found;
  assign o_sram_req = i_req[win];

  always_ff @(posedge aclk or negedge hard_resetn) begin
    if (!hard_resetn) begin
      last_q <= PTR_W'(N_PORTS - 1);  // Port 0 goes first
    end else if (found) begin
      last_q <= win;
    end
  end

  a_gnt_onehot: assert property (@(posedge aclk) disable iff (!hard_resetn)
    $onehot0(o_gnt));

  a_gnt_to_req: assert property (@(posedge aclk) disable iff (!hard_resetn)
    (o_gnt & ~i_req_valid) == '0);

endmodule

/* design/sram_array.sv */
`timescale 1ns/1ns

module sram_array import mem_bus_pkg::*; (
  input  logic      aclk,
  input  logic      i_en,
  input  sram_req_t i_req,
  output data_t     o_rdata
);

  localparam int DEPTH = 2 ** WORD_AW;

  // ==================================================
  // Storage
  // ==================================================
  data_t mem [DEPTH];
  data_t rdata_q;

  always_ff @(posedge aclk) begin
    if (i_en && i_req.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_req.strb[b]) begin
          mem[i_req.waddr][8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered read, one cycle after the grant
  always_ff @(posedge aclk) begin
    if (i_en && !i_req.we) begin
      rdata_q <= mem[i_req.waddr];
    end
  end

  assign o_rdata = rdata_q;

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_shared_sram -f sim.f -o tb_shared_sram \
  && ./obj_dir/tb_shared_sram \
  || exit 1

/* sim.f */
design/mem_bus_pkg.sv
design/axi_sram_port.sv
design/sram_arbiter.sv
design/sram_array.sv
design/bus_idle_watchdog.sv
design/shared_sram_top.sv
testbench/tb_clock_gen.sv
testbench/tb_shared_sram.sv

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic aclk,
  output logic hard_resetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Release lines up with the stimulus offset
  initial begin
    hard_resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #2 hard_resetn = 1'b1;
  end

endmodule

/* testbench/tb_shared_sram.sv */
`timescale 1ns/1ns

module tb_shared_sram import mem_bus_pkg::*; ();

  localparam int               N_PORTS          = 3;
  localparam int               IDLE_LIMIT       = 64;
  localparam logic [N_PORTS-1:0] CHECK_ALIGN_MASK = 3'b011;  // Port 2 unchecked
  localparam int               N_RAND           = 300;
  localparam int               REGION_WORDS     = 16;
  localparam int               TIMEOUT_CYCLES   = 20000;  // 3 x 300 x ~8 cycles plus margin
  localparam logic [31:0]      SEED             = 32'h47059a08;

  logic               aclk;
  logic               hard_resetn;
  logic [N_PORTS-1:0] aw_valid;
  logic [N_PORTS-1:0] w_valid;
  logic [N_PORTS-1:0] ar_valid;
  logic [N_PORTS-1:0] b_ready;
  logic [N_PORTS-1:0] r_ready;
  aw_t                aw [N_PORTS];
  w_t                 w [N_PORTS];
  ar_t                ar [N_PORTS];
  logic [N_PORTS-1:0] aw_ready;
  logic [N_PORTS-1:0] w_ready;
  logic [N_PORTS-1:0] b_valid;
  logic [N_PORTS-1:0] ar_ready;
  logic [N_PORTS-1:0] r_valid;
  resp_t              b_resp [N_PORTS];
  r_t                 r [N_PORTS];
  logic               o_timeout;

  data_t ref_mem [2**WORD_AW];
  resp_t exp_b [N_PORTS][$];  // Expected responses in order per port
  r_t    exp_r [N_PORTS][$];
  int    cycle_cnt = 0;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) tb_clock_gen_i (
    .aclk        (aclk),
    .hard_resetn (hard_resetn)
  );

  shared_sram_top #(
    .N_PORTS          (N_PORTS),
    .IDLE_LIMIT       (IDLE_LIMIT),
    .CHECK_ALIGN_MASK (CHECK_ALIGN_MASK)
  ) shared_sram_top_i (
    .aclk        (aclk),
    .hard_resetn (hard_resetn),
    .i_aw_valid  (aw_valid),
    .i_aw        (aw),
    .i_w_valid   (w_valid),
    .i_w         (w),
    .i_b_ready   (b_ready),
    .i_ar_valid  (ar_valid),
    .i_ar        (ar),
    .i_r_ready   (r_ready),
    .o_aw_ready  (aw_ready),
    .o_w_ready   (w_ready),
    .o_b_valid   (b_valid),
    .o_b_resp    (b_resp),
    .o_ar_ready  (ar_ready),
    .o_r_valid   (r_valid),
    .o_r         (r),
    .o_timeout   (o_timeout)
  );

  // ==================================================
  // Reference model and checks
  // ==================================================
  function automatic r_t expected_word(input int p, input addr_t addr, input data_t old_word,
                                       input w_t wd, input logic is_write);
    r_t res;
    res.resp = (CHECK_ALIGN_MASK[p] && addr[1:0] != 2'b00) ? RESP_SLVERR : RESP_OKAY;
    res.data = old_word;
    if (res.resp == RESP_SLVERR) begin
      if (!is_write) res.data = '0;  // Memory untouched on a write
    end else if (is_write) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wd.strb[b]) res.data[8*b +: 8] = wd.data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t region_addr(input int p, input int word);
    return addr_t'(p * 256 + word * 4);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                               $time, name, exp, got));
    end
  endtask

  task automatic check_rdata(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                               $time, name, exp, got));
    end
  endtask

  task automatic check_timeout(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                               $time, name, exp, got));
    end
  endtask

  task automatic check_ctrl(input string name, input logic [N_PORTS-1:0] got,
                            input logic [N_PORTS-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                               $time, name, exp, got));
    end
  endtask

  task automatic check_quiet();
    check_ctrl("o_aw_ready", aw_ready, '0);
    check_ctrl("o_w_ready", w_ready, '0);
    check_ctrl("o_ar_ready", ar_ready, '0);
    check_ctrl("o_b_valid", b_valid, '0);
    check_ctrl("o_r_valid", r_valid, '0);
    check_timeout("o_timeout", o_timeout, 1'b0);
  endtask

  // Responses are compared where the handshake completes
  always @(negedge aclk) begin : compare_responses
    r_t exp_rd;
    if (hard_resetn) begin
      for (int p = 0; p < N_PORTS; p++) begin
        if (b_valid[p] && b_ready[p]) begin
          if (exp_b[p].size() == 0) begin
            report_failure($sformatf("Write response on port %0d with none outstanding", p));
          end else begin
            check_resp($sformatf("o_b_resp[%0d]", p), b_resp[p], exp_b[p].pop_front());
          end
        end
        if (r_valid[p] && r_ready[p]) begin
          if (exp_r[p].size() == 0) begin
            report_failure($sformatf("Read response on port %0d with none outstanding", p));
          end else begin
            exp_rd = exp_r[p].pop_front();
            check_resp($sformatf("o_r[%0d].resp", p), r[p].resp, exp_rd.resp);
            check_rdata($sformatf("o_r[%0d].data", p), r[p].data, exp_rd.data);
          end
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ==================================================
  // Bus driver tasks
  // ==================================================
  task automatic wait_resp(input int p, input logic is_write);
    int delay;
    delay = $urandom % 4;  // Back-pressure
    do @(negedge aclk); while (!(is_write ? b_valid[p] : r_valid[p]));
    repeat (delay) @(negedge aclk);
    @(posedge aclk);
    #2;
    if (is_write) b_ready[p] = 1'b1;
    else r_ready[p] = 1'b1;
    @(negedge aclk);
    if (!(is_write ? b_valid[p] : r_valid[p])) begin
      report_failure($sformatf("Port %0d dropped its response while ready was low", p));
    end
    @(posedge aclk);
    #2;
    b_ready[p] = 1'b0;
    r_ready[p] = 1'b0;
  endtask

  task automatic write_txn(input int p, input addr_t addr, input w_t wd);
    r_t exp;
    exp = expected_word(p, addr, ref_mem[addr[ADDR_W-1:2]], wd, 1'b1);
    ref_mem[addr[ADDR_W-1:2]] = exp.data;
    exp_b[p].push_back(exp.resp);
    aw_valid[p] = 1'b1;
    aw[p].addr  = addr;
    w_valid[p]  = 1'b1;
    w[p]        = wd;
    do @(negedge aclk); while (!aw_ready[p]);
    if (!w_ready[p]) begin
      report_failure($sformatf("Port %0d raised aw_ready without w_ready", p));
    end
    @(posedge aclk);
    #2;
    aw_valid[p] = 1'b0;
    w_valid[p]  = 1'b0;
    wait_resp(p, 1'b1);
  endtask

  task automatic read_txn(input int p, input addr_t addr);
    exp_r[p].push_back(expected_word(p, addr, ref_mem[addr[ADDR_W-1:2]], '0, 1'b0));
    ar_valid[p] = 1'b1;
    ar[p].addr  = addr;
    do @(negedge aclk); while (!ar_ready[p]);
    @(posedge aclk);
    #2;
    ar_valid[p] = 1'b0;
    wait_resp(p, 1'b0);
  endtask

  task automatic preload_region(input int p);
    w_t wd;
    for (int i = 0; i < REGION_WORDS; i++) begin
      wd.data = $urandom;
      wd.strb = '1;
      write_txn(p, region_addr(p, i), wd);
    end
  endtask

  task automatic directed_rw(input int p);
    w_t    wd;
    strb_t strbs [4] = '{4'hf, 4'h5, 4'h8, 4'h0};
    for (int i = 0; i < 4; i++) begin
      wd.data = $urandom;
      wd.strb = strbs[i];
      write_txn(p, region_addr(p, 2), wd);
      read_txn(p, region_addr(p, 2));
    end
  endtask

  task automatic random_traffic(input int p);
    w_t    wd;
    addr_t addr;
    for (int n = 0; n < N_RAND; n++) begin
      addr = region_addr(p, $urandom % REGION_WORDS);
      if ($urandom % 2 == 0) begin
        wd.data = $urandom;
        wd.strb = strb_t'($urandom);
        write_txn(p, addr, wd);
      end else begin
        read_txn(p, addr);
      end
    end
  endtask

  task automatic misaligned_checks();
    w_t wd;
    for (int p = 0; p < N_PORTS; p++) begin
      wd.data = $urandom;
      wd.strb = '1;
      write_txn(p, region_addr(p, 5) + 16'd1, wd);
      read_txn(p, region_addr(p, 5));  // Old word on checked ports
      read_txn(p, region_addr(p, 5) + 16'd3);
    end
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    w_t wd;
    void'($urandom(SEED));
    aw_valid = '0;
    w_valid  = '0;
    ar_valid = '0;
    b_ready  = '0;
    r_ready  = '0;
    for (int p = 0; p < N_PORTS; p++) begin
      aw[p] = '0;
      w[p]  = '0;
      ar[p] = '0;
    end

    @(negedge aclk);
    while (!hard_resetn) begin
      check_quiet();
      @(negedge aclk);
    end
    check_quiet();  // First cycle out of reset
    @(posedge aclk);
    #2;

    fork
      preload_region(0);
      preload_region(1);
      preload_region(2);
    join
    for (int p = 0; p < N_PORTS; p++) directed_rw(p);
    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
    join
    misaligned_checks();

    // Word in port 0's region written through port 2
    wd.data = $urandom;
    wd.strb = '1;
    write_txn(2, region_addr(0, 12), wd);
    read_txn(0, region_addr(0, 12));
    read_txn(1, region_addr(0, 12));
    check_timeout("o_timeout", o_timeout, 1'b0);

    repeat (IDLE_LIMIT) begin
      @(negedge aclk);
      check_timeout("o_timeout", o_timeout, 1'b0);
    end
    @(negedge aclk);
    check_timeout("o_timeout", o_timeout, 1'b1);
    @(posedge aclk);
    #2;
    write_txn(1, region_addr(1, 7), wd);
    read_txn(1, region_addr(1, 7));
    check_timeout("o_timeout", o_timeout, 1'b1);  // Sticky

    if (exp_b[0].size() + exp_b[1].size() + exp_b[2].size() +
        exp_r[0].size() + exp_r[1].size() + exp_r[2].size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      report_failure("Responses still outstanding at the end of the run");
    end
  end

endmodule
